/* hdl/gpu_pkg.sv */
package gpu_pkg;

    // transaction states
    typedef enum logic [3:0]
    {
        IDLE        = 4'd0,   // high command nibble arrives here
        COMMAND     = 4'd1,   // low command nibble, next phase decided
        READ        = 4'd2,   // data from the host
        WRITE_DUMMY = 4'd4,   // turnaround before the slave drives
        WRITE       = 4'd8,   // data to the host
        DONE        = 4'd15   // waits for cs to rise
    } spi_state_t;

    // bit 7 marks a read phase, bit 6 a write phase
    typedef enum logic [7:0]
    {
        CMD_DISABLE_OUTPUT = 8'h00,
        CMD_ENABLE_OUTPUT  = 8'h01,
        CMD_READ_STATUS0   = 8'h40,
        CMD_READ_MAGIC     = 8'h60,
        CMD_FB_WRITE       = 8'h82
    } command_t;

    typedef logic [3:0]  nibble_t;   // one transfer on the four data lines
    typedef logic [16:0] fb_addr_t;
    typedef logic [7:0]  pixel_t;
    typedef logic [15:0] count_t;    // saturating phase counter

    // 320 x 240 framebuffer
    localparam fb_addr_t FB_PIXELS = 17'd76800;

    // start address is three bytes on the wire
    localparam count_t FB_ADDR_NIBBLES = 16'd6;

    localparam count_t WRITE_DUMMY_CYCLES = 16'd2;

    localparam logic [15:0] MAGIC_NUMBER = 16'hA5C3;
    localparam count_t MAGIC_NIBBLES = 16'd4;

    localparam count_t STATUS_NIBBLES = 16'd2;

    // fixed upper bits of status register 0
    localparam logic [4:0] STATUS_ID = 5'b10110;

endpackage

/* hdl/gpu_status.sv */
module gpu_status
    import gpu_pkg::*;
(
    input  logic     sclk,
    input  logic     reset,
    input  logic     hblank,
    input  logic     vblank,
    input  command_t command,
    input  logic     command_done,
    output pixel_t   status_byte,
    output logic     output_enabled
);

    // blanking comes from the pixel clock domain
    logic [1:0] hblank_sync;
    logic [1:0] vblank_sync;

    always_ff @(posedge sclk)
    begin
        hblank_sync <= {hblank_sync[0], hblank};
        vblank_sync <= {vblank_sync[0], vblank};
    end

    always_ff @(posedge sclk)
    begin
        if (reset)
            output_enabled <= 1'b0;
        else if (command_done)
        begin
            case (command)
                CMD_ENABLE_OUTPUT:  output_enabled <= 1'b1;
                CMD_DISABLE_OUTPUT: output_enabled <= 1'b0;
                default:            output_enabled <= output_enabled;
            endcase
        end
    end

    assign status_byte = {STATUS_ID, hblank_sync[1], vblank_sync[1], output_enabled};

endmodule

/* hdl/spi_cmd_fsm.sv */
module spi_cmd_fsm
    import gpu_pkg::*;
(
    input  logic       sclk,
    input  logic       reset,
    input  logic       cs,
    input  nibble_t    quad_in,
    output spi_state_t state,
    output command_t   command,
    output count_t     phase_count,
    output logic       command_done
);

    nibble_t    cmd_hi;          // high command nibble
    logic [7:0] cmd_byte;
    spi_state_t next_state;
    count_t     write_nibbles;

    function automatic logic cmd_defined(input logic [7:0] code);
        case (code)
            CMD_FB_WRITE, CMD_READ_STATUS0, CMD_READ_MAGIC,
            CMD_DISABLE_OUTPUT, CMD_ENABLE_OUTPUT:
                cmd_defined = 1'b1;
            default:
                cmd_defined = 1'b0;
        endcase
    endfunction

    // phase bits only count for known opcodes
    function automatic logic cmd_has_read(input logic [7:0] code);
        cmd_has_read = cmd_defined(code) & code[7];
    endfunction

    function automatic logic cmd_has_write(input logic [7:0] code);
        cmd_has_write = cmd_defined(code) & code[6];
    endfunction

    assign cmd_byte = {cmd_hi, quad_in};

    // length of the response for the latched command
    always_comb
    begin
        case (command)
            CMD_READ_STATUS0: write_nibbles = STATUS_NIBBLES;
            CMD_READ_MAGIC:   write_nibbles = MAGIC_NIBBLES;
            default:          write_nibbles = 16'd1;
        endcase
    end

    always_comb
    begin
        case (state)
            IDLE:
                next_state = COMMAND;
            COMMAND:
                if (cmd_has_read(cmd_byte))
                    next_state = READ;
                else if (cmd_has_write(cmd_byte))
                    next_state = WRITE_DUMMY;
                else
                    next_state = DONE;   // output commands and unknown codes
            READ:
                next_state = READ;       // burst runs until cs rises
            WRITE_DUMMY:
                next_state = (phase_count >= WRITE_DUMMY_CYCLES - 16'd1) ? WRITE : WRITE_DUMMY;
            WRITE:
                next_state = (phase_count >= write_nibbles - 16'd1) ? DONE : WRITE;
            DONE:
                next_state = DONE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge sclk)
    begin
        if (reset || cs)
        begin
            state <= IDLE;
            phase_count <= '0;
            command_done <= 1'b0;
        end
        else
        begin
            state <= next_state;
            command_done <= (state == COMMAND);
            if (next_state != state)
                phase_count <= '0;
            else if (phase_count != '1)
                phase_count <= phase_count + 16'd1;   // saturate on long bursts
        end
    end

    // command shift register
    always_ff @(posedge sclk)
    begin
        if (!cs && state == IDLE)
            cmd_hi <= quad_in;
        if (!cs && state == COMMAND)
            command <= command_t'(cmd_byte);
    end

endmodule

/* hdl/spi_response_tx.sv */
module spi_response_tx
    import gpu_pkg::*;
(
    input  logic       sclk,
    input  logic       reset,
    input  logic       cs,
    input  spi_state_t state,
    input  command_t   command,
    input  count_t     phase_count,
    input  pixel_t     status_byte,
    output nibble_t    quad_out,
    output logic       quad_oe
);

    logic [15:0] resp_word;   // left aligned word sent msb first
    logic [15:0] next_word;

    always_comb
    begin
        case (command)
            CMD_READ_MAGIC: next_word = MAGIC_NUMBER;
            default:        next_word = {status_byte, 8'h00};
        endcase
    end

    // mode 0 drives on the falling edge, host samples on the rising one
    always_ff @(negedge sclk)
    begin
        if (reset)
            quad_oe <= 1'b0;
        else
            quad_oe <= (state == WRITE) && !cs;
    end

    always_ff @(negedge sclk)
    begin
        // freeze the word during the dummy cycles so it stays stable
        if (state == WRITE_DUMMY)
            resp_word <= next_word;

        case (phase_count[1:0])
            2'd0: quad_out <= resp_word[15:12];
            2'd1: quad_out <= resp_word[11:8];
            2'd2: quad_out <= resp_word[7:4];
            default: quad_out <= resp_word[3:0];
        endcase
    end

endmodule

/* hdl/fb_write_port.sv */
module fb_write_port
    import gpu_pkg::*;
(
    input  logic       sclk,
    input  logic       reset,
    input  nibble_t    quad_in,
    input  spi_state_t state,
    input  command_t   command,
    input  count_t     phase_count,
    output fb_addr_t   fb_addr,
    output pixel_t     fb_data,
    output logic       fb_we
);

    logic    fb_active;
    logic    addr_phase;
    logic    second_nibble;   // next nibble completes a pixel
    logic    pixel_valid;
    nibble_t pixel_hi;

    assign fb_active = (state == READ) && (command == CMD_FB_WRITE);
    assign addr_phase = phase_count < FB_ADDR_NIBBLES;

    // an abort edge leaves READ, which masks a pixel completed by a stray nibble
    assign fb_we = pixel_valid && fb_active;

    always_ff @(posedge sclk)
    begin
        if (reset)
        begin
            second_nibble <= 1'b0;
            pixel_valid <= 1'b0;
        end
        else
        begin
            second_nibble <= fb_active && !addr_phase && !second_nibble;
            pixel_valid <= fb_active && !addr_phase && second_nibble;
        end
    end

    always_ff @(posedge sclk)
    begin
        if (fb_active && addr_phase)
            fb_addr <= {fb_addr[12:0], quad_in};   // keeps the low 17 of 24 bits
        else if (fb_we)
            fb_addr <= (fb_addr == FB_PIXELS - 17'd1) ? '0 : fb_addr + 17'd1;

        if (fb_active && !addr_phase)
        begin
            if (!second_nibble)
                pixel_hi <= quad_in;
            else
                fb_data <= {pixel_hi, quad_in};
        end
    end

endmodule

/* hdl/spi_gpu_top.sv */
module spi_gpu_top
    import gpu_pkg::*;
(
    input  logic     sclk,
    input  logic     reset,
    input  logic     cs,
    input  nibble_t  quad_in,
    input  logic     hblank,
    input  logic     vblank,
    output nibble_t  quad_out,
    output logic     quad_oe,
    output fb_addr_t fb_addr,
    output pixel_t   fb_data,
    output logic     fb_we,
    output logic     video_enable
);

    spi_state_t state;
    command_t   command;
    count_t     phase_count;
    logic       command_done;
    pixel_t     status_byte;

    spi_cmd_fsm u_cmd_fsm
    (
        .sclk         (sclk),
        .reset        (reset),
        .cs           (cs),
        .quad_in      (quad_in),
        .state        (state),
        .command      (command),
        .phase_count  (phase_count),
        .command_done (command_done)
    );

    spi_response_tx u_response_tx
    (
        .sclk        (sclk),
        .reset       (reset),
        .cs          (cs),
        .state       (state),
        .command     (command),
        .phase_count (phase_count),
        .status_byte (status_byte),
        .quad_out    (quad_out),
        .quad_oe     (quad_oe)
    );

    fb_write_port u_fb_write_port
    (
        .sclk        (sclk),
        .reset       (reset),
        .quad_in     (quad_in),
        .state       (state),
        .command     (command),
        .phase_count (phase_count),
        .fb_addr     (fb_addr),
        .fb_data     (fb_data),
        .fb_we       (fb_we)
    );

    // output enable flag goes straight to the video pipeline
    gpu_status u_status
    (
        .sclk           (sclk),
        .reset          (reset),
        .hblank         (hblank),
        .vblank         (vblank),
        .command        (command),
        .command_done   (command_done),
        .status_byte    (status_byte),
        .output_enabled (video_enable)
    );

endmodule

/* tb/tb_spi_gpu.sv */
module tb_spi_gpu
    import gpu_pkg::*;
();

    logic     sclk;
    logic     reset;
    logic     cs;
    nibble_t  quad_in;
    logic     hblank;
    logic     vblank;
    nibble_t  quad_out;
    logic     quad_oe;
    fb_addr_t fb_addr;
    pixel_t   fb_data;
    logic     fb_we;
    logic     video_enable;

    fb_addr_t wr_addr_q[$];     // framebuffer writes seen by the monitor
    pixel_t   wr_data_q[$];
    pixel_t   exp_pixel_q[$];   // pixels sent in the current burst

    spi_gpu_top uut
    (
        .sclk         (sclk),
        .reset        (reset),
        .cs           (cs),
        .quad_in      (quad_in),
        .hblank       (hblank),
        .vblank       (vblank),
        .quad_out     (quad_out),
        .quad_oe      (quad_oe),
        .fb_addr      (fb_addr),
        .fb_data      (fb_data),
        .fb_we        (fb_we),
        .video_enable (video_enable)
    );

    initial
    begin
        sclk = 1'b0;
        forever #50 sclk = ~sclk;
    end

    // a write strobe lasts a full cycle, so each falling edge sees it once
    always @(negedge sclk)
    begin
        if (fb_we === 1'b1)
        begin
            wr_addr_q.push_back(fb_addr);
            wr_data_q.push_back(fb_data);
        end
    end

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_equal(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
            abort_run();
        end
    endtask

    task automatic send_nibble(input nibble_t value);
        @(posedge sclk);
        quad_in <= value;
    endtask

    // slave samples each command nibble on the rising edge after it is driven
    task automatic send_command(input logic [7:0] code);
        @(posedge sclk);
        cs <= 1'b0;
        quad_in <= code[7:4];
        @(posedge sclk);
        quad_in <= code[3:0];
    endtask

    task automatic end_transaction();
        @(posedge sclk);
        cs <= 1'b1;
        repeat (2) @(posedge sclk);
    endtask

    task automatic collect_nibbles(input string test_name, input int count,
                                   output logic [15:0] word);
        int waited;
        int i;
        word = '0;
        waited = 0;
        @(posedge sclk);
        while (quad_oe !== 1'b1 && waited < 20)
        begin
            @(posedge sclk);
            waited++;
        end
        if (quad_oe !== 1'b1)
        begin
            $display("Timeout in %s: the slave never drove the data lines", test_name);
            abort_run();
        end
        for (i = 0; i < count; i++)
        begin
            if (i > 0)
                @(posedge sclk);
            check_equal({test_name, " quad_oe"}, 32'd1, 32'(quad_oe));
            word = {word[11:0], quad_out};   // msb nibble arrives first
        end
        @(posedge sclk);
        check_equal({test_name, " quad_oe release"}, 32'd0, 32'(quad_oe));
    endtask

    task automatic read_register(input string test_name, input logic [7:0] code,
                                 input int count, output logic [15:0] word);
        send_command(code);
        collect_nibbles(test_name, count, word);
        end_transaction();
    endtask

    task automatic write_burst(input fb_addr_t start, input logic [6:0] upper,
                               input int count, input logic extra_nibble);
        logic [23:0] addr_word;
        logic [31:0] rnd;
        int          i;
        exp_pixel_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        addr_word = {upper, start};   // upper bits are outside the 17-bit address
        send_command(CMD_FB_WRITE);
        for (i = 0; i < 6; i++)
        begin
            send_nibble(addr_word[23:20]);
            addr_word = addr_word << 4;
        end
        for (i = 0; i < count; i++)
        begin
            rnd = $urandom;
            exp_pixel_q.push_back(rnd[7:0]);
            send_nibble(rnd[7:4]);
            send_nibble(rnd[3:0]);
        end
        if (extra_nibble)
            send_nibble(4'hE);   // half a pixel that must be dropped
        end_transaction();
    endtask

    task automatic verify_writes(input string test_name, input fb_addr_t start);
        logic [31:0] exp_addr;
        int          i;
        check_equal({test_name, " write count"}, 32'(exp_pixel_q.size()),
                    32'(wr_addr_q.size()));
        for (i = 0; i < exp_pixel_q.size(); i++)
        begin
            exp_addr = (32'(start) + 32'(i)) % 32'd76800;   // 320 x 240 wrap
            check_equal({test_name, " address"}, exp_addr, 32'(wr_addr_q[i]));
            check_equal({test_name, " data"}, 32'(exp_pixel_q[i]), 32'(wr_data_q[i]));
        end
    endtask

    task automatic test_magic_read();
        logic [15:0] word;
        read_register("magic read", CMD_READ_MAGIC, 4, word);
        check_equal("magic read", 32'h0000_a5c3, 32'(word));
    endtask

    task automatic test_status_read();
        logic [15:0] word;
        logic [7:0]  expected;
        int          combo;
        for (combo = 0; combo < 4; combo++)
        begin
            @(posedge sclk);
            hblank <= combo[1];
            vblank <= combo[0];
            repeat (4) @(posedge sclk);   // two-flop synchronizers
            read_register("status read", CMD_READ_STATUS0, 2, word);
            expected = {5'b10110, combo[1], combo[0], 1'b0};
            check_equal("status read", 32'(expected), 32'(word[7:0]));
        end
    endtask

    task automatic test_output_enable();
        logic [15:0] word;
        @(posedge sclk);
        hblank <= 1'b0;
        vblank <= 1'b0;
        repeat (4) @(posedge sclk);
        send_command(CMD_ENABLE_OUTPUT);
        end_transaction();
        check_equal("output enable", 32'd1, 32'(video_enable));
        read_register("output enable status", CMD_READ_STATUS0, 2, word);
        check_equal("output enable status", 32'h0000_00b1, 32'(word[7:0]));
        send_command(CMD_DISABLE_OUTPUT);
        end_transaction();
        check_equal("output disable", 32'd0, 32'(video_enable));
        read_register("output disable status", CMD_READ_STATUS0, 2, word);
        check_equal("output disable status", 32'h0000_00b0, 32'(word[7:0]));
    endtask

    task automatic test_pixel_burst();
        logic [31:0] rnd;
        fb_addr_t    start;
        int          count;
        rnd = $urandom % 32'd76800;
        start = rnd[16:0];
        rnd = $urandom % 32'd20;
        count = 1 + int'(rnd);
        rnd = $urandom;
        write_burst(start, rnd[6:0], count, 1'b0);
        verify_writes("pixel burst", start);
    endtask

    task automatic test_wrap_and_partial();
        write_burst(17'd76798, 7'd0, 4, 1'b1);   // 76798, 76799, 0, 1
        verify_writes("wrap and partial pixel", 17'd76798);
    endtask

    task automatic test_undefined_opcode();
        logic [31:0] rnd;
        logic [15:0] word;
        int          i;
        wr_addr_q.delete();
        wr_data_q.delete();
        send_command(8'hff);
        for (i = 0; i < 14; i++)
        begin
            @(posedge sclk);
            check_equal("undefined opcode quad_oe", 32'd0, 32'(quad_oe));
            rnd = $urandom;
            quad_in <= rnd[3:0];
        end
        end_transaction();
        check_equal("undefined opcode writes", 32'd0, 32'(wr_addr_q.size()));
        read_register("magic after undefined opcode", CMD_READ_MAGIC, 4, word);
        check_equal("magic after undefined opcode", 32'h0000_a5c3, 32'(word));
    endtask

    initial
    begin
        void'($urandom(32'h59ed));
        reset = 1'b1;
        cs = 1'b1;
        quad_in = 4'h0;
        hblank = 1'b0;
        vblank = 1'b0;
        repeat (4) @(posedge sclk);
        reset <= 1'b0;
        @(posedge sclk);
        check_equal("reset state", 32'(IDLE), 32'(uut.state));
        check_equal("reset quad_oe", 32'd0, 32'(quad_oe));
        check_equal("reset command_done", 32'd0, 32'(uut.command_done));
        check_equal("reset video_enable", 32'd0, 32'(video_enable));
        test_magic_read();
        test_status_read();
        test_output_enable();
        test_pixel_burst();
        test_wrap_and_partial();
        test_undefined_opcode();
        $display("*** PASSED ***");
        $finish;
    end

    // watchdog for the whole test sequence
    initial
    begin
        #500000;
        $display("Timeout: the test sequence did not finish");
        abort_run();
    end

endmodule

/* filelist.f */
hdl/gpu_pkg.sv
hdl/gpu_status.sv
hdl/spi_cmd_fsm.sv
hdl/spi_response_tx.sv
hdl/fb_write_port.sv
hdl/spi_gpu_top.sv
tb/tb_spi_gpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it, exit status follows the run
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_spi_gpu \
    && ./obj_dir/Vtb_spi_gpu \
    || { echo "simulation failed"; exit 1; }

echo "simulation finished"
